// ==== board_io.f ====
source/board_io_pkg.sv
source/clock_ring_divider.sv
source/pad_input_sync.sv
source/gpio_regs.sv
source/led_driver.sv
source/board_io_top.sv
verif/tb_board_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_board_io
FILELIST  = board_io.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_board_io.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_board_io;

	localparam int unsigned N_PADS = board_io_pkg::N_PADS;
	localparam int unsigned N_DPAD = board_io_pkg::N_DPAD;
	localparam int unsigned N_LEDS = board_io_pkg::N_LEDS;

	localparam int unsigned DEBOUNCE_CYCLES = 4;
	localparam logic [N_DPAD-1:0] DPAD_INVERT = 4'b0100;
	localparam logic [N_LEDS-1:0] LED_INVERT = 7'b0000011;
	localparam int unsigned PIX_RATIO = 5;
	localparam int unsigned SYS_RATIO = 9;

	localparam int unsigned CLK_PERIOD = 100;
	localparam int unsigned RESET_CYCLES = 5;
	localparam int unsigned SETTLE_CYCLES = 2 + DEBOUNCE_CYCLES + 3;
	localparam int unsigned READ_TIMEOUT = 8;
	localparam int unsigned CLOCK_CHECK_CYCLES = 90;
	localparam int unsigned REG_WRITES = 40;
	localparam int unsigned LOOP_ROUNDS = 10;
	localparam int unsigned DEBOUNCE_ROUNDS = 12;
	localparam int unsigned LED_ROUNDS = 12;

	// Upper bound of cycles per test, used by the watchdog
	localparam int unsigned TEST_CYCLES = RESET_CYCLES + 10 + CLOCK_CHECK_CYCLES
		+ REG_WRITES * 8 + LOOP_ROUNDS * 8
		+ DEBOUNCE_ROUNDS * (2 * SETTLE_CYCLES + 16) + LED_ROUNDS * (SETTLE_CYCLES + 3);
	localparam int unsigned WATCHDOG_CYCLES = TEST_CYCLES + 200;

	logic                    clk_bit = 1'b0;
	logic                    rst_n_por;
	logic [N_DPAD-1:0]       dpad;
	board_io_pkg::gpio_req_t req;
	logic [N_PADS-1:0]       rdata;
	logic                    rdata_valid;
	logic [N_LEDS-1:0]       led;
	logic                    clk_pix;
	logic                    clk_sys;

	integer seed = 32'h906d;

	// Register model and settled raw button levels
	logic [N_PADS-1:0] m_out = '0;
	logic [N_PADS-1:0] m_oe = '0;
	logic [N_DPAD-1:0] m_dpad = '0;

	logic [N_PADS-1:0] exp_q[$];
	logic [N_PADS-1:0] rdata_exp;
	int unsigned       bit_edges = 0;
	string             cur_test = "none";
	int                test_errors = 0;
	int                total_errors = 0;
	int                tests_run = 0;
	int                tests_failed = 0;

	board_io_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.DPAD_INVERT     (DPAD_INVERT),
		.LED_INVERT      (LED_INVERT)
	) DUT (
		.clk_bit     (clk_bit),
		.rst_n_por   (rst_n_por),
		.dpad        (dpad),
		.req         (req),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.led         (led),
		.clk_pix     (clk_pix),
		.clk_sys     (clk_sys)
	);

	always #(CLK_PERIOD / 2) clk_bit = ~clk_bit;

	// Bit clock edges seen by the dividers since reset release
	always @(posedge clk_bit) begin
		if (rst_n_por) begin
			bit_edges <= bit_edges + 1;
		end
	end

	// Divider output after a number of right rotations of the preset ring
	function automatic logic ring_bit(input int unsigned ratio, input int unsigned edges);
		return (edges % ratio) >= (ratio / 2);
	endfunction

	function automatic logic [N_PADS-1:0] expected_padin();
		logic [N_PADS-1:0] v;
		v = m_out & m_oe;
		v[N_DPAD-1:0] = m_dpad ^ DPAD_INVERT;
		return v;
	endfunction

	function automatic logic [N_PADS-1:0] expected_read(input logic [1:0] addr);
		case (addr)
			board_io_pkg::REG_OUT: return m_out;
			board_io_pkg::REG_OE:  return m_oe;
			board_io_pkg::REG_IN:  return expected_padin();
			default:               return '0;
		endcase
	endfunction

	// Buttons U, D, L, R on the top LEDs, enabled outputs LED0 to LED2 below
	function automatic logic [N_LEDS-1:0] led_map(input logic [N_PADS-1:0] padin,
		input logic [N_PADS-1:0] on);
		logic [N_LEDS-1:0] lv;
		lv[6] = padin[board_io_pkg::PIN_DPAD_U];
		lv[5] = padin[board_io_pkg::PIN_DPAD_D];
		lv[4] = padin[board_io_pkg::PIN_DPAD_L];
		lv[3] = padin[board_io_pkg::PIN_DPAD_R];
		lv[2] = on[board_io_pkg::PIN_LED0];
		lv[1] = on[board_io_pkg::PIN_LED1];
		lv[0] = on[board_io_pkg::PIN_LED2];
		return lv ^ LED_INVERT;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
		test_errors++;
		total_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		test_errors++;
		total_errors++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", cur_test, test_errors);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_bit);
			req <= '0;
		end
	endtask

	task automatic drive_dpad(input logic [N_DPAD-1:0] v);
		@(posedge clk_bit);
		dpad <= v;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [N_PADS-1:0] data);
		board_io_pkg::gpio_req_t r;
		r = '0;
		r.wr = 1'b1;
		r.addr = addr;
		r.wdata = data;
		@(posedge clk_bit);
		req <= r;
		case (addr)
			board_io_pkg::REG_OUT:    m_out = data;
			board_io_pkg::REG_OE:     m_oe = data;
			board_io_pkg::REG_TOGGLE: m_out = m_out ^ data;
			default: begin
			end
		endcase
	endtask

	task automatic read_reg(input logic [1:0] addr);
		board_io_pkg::gpio_req_t r;
		r = '0;
		r.rd = 1'b1;
		r.addr = addr;
		@(posedge clk_bit);
		req <= r;
		exp_q.push_back(expected_read(addr));
	endtask

	task automatic wait_reads_done();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < READ_TIMEOUT) begin
			@(negedge clk_bit);
			n++;
		end
		if (exp_q.size() != 0) begin
			report_problem("a read got no rdata_valid pulse in time");
			exp_q.delete();
		end
	endtask

	// Each valid pulse answers the oldest pending read
	always @(negedge clk_bit) begin
		if (rst_n_por && rdata_valid) begin
			if (exp_q.size() == 0) begin
				report_problem("rdata_valid pulsed with no read pending");
			end else begin
				rdata_exp = exp_q.pop_front();
				if (rdata !== rdata_exp) report_mismatch("rdata", 32'(rdata_exp), 32'(rdata));
			end
		end
	end

	task automatic test_reset_state();
		start_test("reset_state");
		@(negedge clk_bit);
		if (led !== LED_INVERT) report_mismatch("led", 32'(LED_INVERT), 32'(led));
		if (rdata_valid !== 1'b0) report_mismatch("rdata_valid", 32'd0, 32'(rdata_valid));
		read_reg(board_io_pkg::REG_OUT);
		read_reg(board_io_pkg::REG_OE);
		idle_cycles(1);
		wait_reads_done();
		finish_test();
	endtask

	task automatic test_clock_division();
		logic exp_pix;
		logic exp_sys;
		start_test("clock_division");
		repeat (CLOCK_CHECK_CYCLES) begin
			@(negedge clk_bit);
			exp_pix = ring_bit(PIX_RATIO, bit_edges);
			exp_sys = ring_bit(SYS_RATIO, bit_edges);
			if (clk_pix !== exp_pix) report_mismatch("clk_pix", 32'(exp_pix), 32'(clk_pix));
			if (clk_sys !== exp_sys) report_mismatch("clk_sys", 32'(exp_sys), 32'(clk_sys));
		end
		finish_test();
	endtask

	task automatic test_register_access();
		logic [31:0] rnd;
		logic [1:0]  addr;
		start_test("register_access");
		for (int i = 0; i < REG_WRITES; i++) begin
			rnd = $random(seed);
			case (rnd % 32'd3)
				32'd0:   addr = board_io_pkg::REG_OUT;
				32'd1:   addr = board_io_pkg::REG_OE;
				default: addr = board_io_pkg::REG_TOGGLE;
			endcase
			write_reg(addr, rnd[15:8]);
			read_reg((addr == board_io_pkg::REG_TOGGLE) ? board_io_pkg::REG_OUT : addr);
			// Second read back to back on some rounds
			if (rnd[16]) read_reg(rnd[18:17]);
			idle_cycles(1);
			wait_reads_done();
		end
		finish_test();
	endtask

	task automatic test_loopback();
		logic [31:0] rnd;
		start_test("loopback");
		for (int i = 0; i < LOOP_ROUNDS; i++) begin
			rnd = $random(seed);
			write_reg(board_io_pkg::REG_OUT, rnd[7:0]);
			write_reg(board_io_pkg::REG_OE, rnd[15:8]);
			read_reg(board_io_pkg::REG_IN);
			idle_cycles(1);
			wait_reads_done();
		end
		finish_test();
	endtask

	task automatic test_debounce();
		logic [31:0]       rnd;
		logic [N_DPAD-1:0] glitch;
		int                dur;
		start_test("debounce");
		for (int i = 0; i < DEBOUNCE_ROUNDS; i++) begin
			rnd = $random(seed);
			m_dpad = rnd[3:0];
			drive_dpad(m_dpad);
			idle_cycles(SETTLE_CYCLES);
			read_reg(board_io_pkg::REG_IN);
			idle_cycles(1);
			wait_reads_done();
			glitch = rnd[7:4];
			if (glitch == '0) glitch = 4'b0001;
			dur = 1 + int'(rnd[15:8] % (DEBOUNCE_CYCLES - 1));
			drive_dpad(m_dpad ^ glitch);
			idle_cycles(dur - 1);
			drive_dpad(m_dpad);
			idle_cycles(SETTLE_CYCLES);
			read_reg(board_io_pkg::REG_IN);
			idle_cycles(1);
			wait_reads_done();
		end
		finish_test();
	endtask

	task automatic test_led_mapping();
		logic [31:0]       rnd;
		logic [N_LEDS-1:0] exp_led;
		start_test("led_mapping");
		for (int i = 0; i < LED_ROUNDS; i++) begin
			rnd = $random(seed);
			case (rnd % 32'd3)
				32'd0: begin
					m_dpad = rnd[11:8];
					drive_dpad(m_dpad);
				end
				32'd1:   write_reg(board_io_pkg::REG_OUT, rnd[15:8]);
				default: write_reg(board_io_pkg::REG_OE, rnd[15:8]);
			endcase
			idle_cycles(SETTLE_CYCLES);
			@(negedge clk_bit);
			exp_led = led_map(expected_padin(), m_out & m_oe);
			if (led !== exp_led) report_mismatch("led", 32'(exp_led), 32'(led));
		end
		finish_test();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_bit);
		$display("Watchdog: run timed out after %0d bit clock cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst_n_por = 1'b0;
		dpad = '0;
		req = '0;
		repeat (RESET_CYCLES) @(posedge clk_bit);
		rst_n_por <= 1'b1;
		test_reset_state();
		test_clock_division();
		test_register_access();
		test_loopback();
		test_debounce();
		test_led_mapping();
		idle_cycles(2);
		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (tests_failed == 0 && total_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/board_io_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module board_io_top #(
	parameter int unsigned                      DEBOUNCE_CYCLES = 4,
	// Left button is wired inverted on the main board
	parameter logic [board_io_pkg::N_DPAD-1:0] DPAD_INVERT     = 4'b0100,
	// LEDs 0 and 1 are active low
	parameter logic [board_io_pkg::N_LEDS-1:0] LED_INVERT      = 7'b0000011
) (
	input  logic                              clk_bit,
	input  logic                              rst_n_por,
	input  logic [board_io_pkg::N_DPAD-1:0]   dpad,
	input  board_io_pkg::gpio_req_t           req,
	output logic [board_io_pkg::N_PADS-1:0]   rdata,
	output logic                              rdata_valid,
	output logic [board_io_pkg::N_LEDS-1:0]   led,
	output logic                              clk_pix,
	output logic                              clk_sys
);

	// Pixel clock at one fifth, system clock at one ninth of the bit clock
	localparam int unsigned PIX_RATIO = 5;
	localparam int unsigned SYS_RATIO = 9;

	logic [board_io_pkg::N_DPAD-1:0] dpad_clean;
	board_io_pkg::pad_state_t        pad_state;

	clock_ring_divider #(
		.RATIO (PIX_RATIO)
	) u_div_pix (
		.clk_bit   (clk_bit),
		.rst_n_por (rst_n_por),
		.clk_div   (clk_pix)
	);

	clock_ring_divider #(
		.RATIO (SYS_RATIO)
	) u_div_sys (
		.clk_bit   (clk_bit),
		.rst_n_por (rst_n_por),
		.clk_div   (clk_sys)
	);

	pad_input_sync #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.DPAD_INVERT     (DPAD_INVERT)
	) u_pad_input_sync (
		.clk_bit    (clk_bit),
		.rst_n_por  (rst_n_por),
		.dpad       (dpad),
		.dpad_clean (dpad_clean)
	);

	gpio_regs u_gpio_regs (
		.clk_bit     (clk_bit),
		.rst_n_por   (rst_n_por),
		.req         (req),
		.dpad_clean  (dpad_clean),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.pad_state   (pad_state)
	);

	led_driver #(
		.LED_INVERT (LED_INVERT)
	) u_led_driver (
		.clk_bit   (clk_bit),
		.rst_n_por (rst_n_por),
		.pad_state (pad_state),
		.led       (led)
	);

endmodule

`default_nettype wire

// ==== source/led_driver.sv ====
`default_nettype none
`timescale 1ns/100ps

module led_driver #(
	parameter logic [board_io_pkg::N_LEDS-1:0] LED_INVERT = '0
) (
	input  logic                              clk_bit,
	input  logic                              rst_n_por,
	input  board_io_pkg::pad_state_t          pad_state,
	output logic [board_io_pkg::N_LEDS-1:0]   led
);

	localparam int unsigned N_LEDS = board_io_pkg::N_LEDS;

	logic [board_io_pkg::N_PADS-1:0] pad_on;
	logic [N_LEDS-1:0]               led_level;

	// Output pads count as lit only when enabled
	assign pad_on = pad_state.padout & pad_state.padoe;

	// Buttons on the top four LEDs and GPIO outputs below
	assign led_level = {
		pad_state.padin[board_io_pkg::PIN_DPAD_U],
		pad_state.padin[board_io_pkg::PIN_DPAD_D],
		pad_state.padin[board_io_pkg::PIN_DPAD_L],
		pad_state.padin[board_io_pkg::PIN_DPAD_R],
		pad_on[board_io_pkg::PIN_LED0],
		pad_on[board_io_pkg::PIN_LED1],
		pad_on[board_io_pkg::PIN_LED2]
	};

	// Reset value LED_INVERT leaves every LED dark
	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			led <= LED_INVERT;
		end else begin
			led <= led_level ^ LED_INVERT;
		end
	end

endmodule

`default_nettype wire

// ==== source/gpio_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module gpio_regs (
	input  logic                              clk_bit,
	input  logic                              rst_n_por,
	input  board_io_pkg::gpio_req_t           req,
	input  logic [board_io_pkg::N_DPAD-1:0]   dpad_clean,
	output logic [board_io_pkg::N_PADS-1:0]   rdata,
	output logic                              rdata_valid,
	output board_io_pkg::pad_state_t          pad_state
);

	localparam int unsigned N_PADS = board_io_pkg::N_PADS;
	localparam int unsigned N_DPAD = board_io_pkg::N_DPAD;

	logic [N_PADS-1:0] out_q;
	logic [N_PADS-1:0] oe_q;
	logic [N_PADS-1:0] pad_drive;
	logic [N_PADS-1:0] padin;
	logic [N_PADS-1:0] rd_mux;

	// A pad only reads back high when it is both driven and enabled
	assign pad_drive = out_q & oe_q;

	// Buttons on the low pads, output loopback on the rest
	assign padin = {pad_drive[N_PADS-1:N_DPAD], dpad_clean};

	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (req.wr) begin
			case (req.addr)
				board_io_pkg::REG_OUT: begin
					out_q <= req.wdata;
				end
				board_io_pkg::REG_OE: begin
					oe_q <= req.wdata;
				end
				board_io_pkg::REG_TOGGLE: begin
					out_q <= out_q ^ req.wdata;
				end
				default: begin
					// IN is read only
				end
			endcase
		end
	end

	always_comb begin
		case (req.addr)
			board_io_pkg::REG_OUT:    rd_mux = out_q;
			board_io_pkg::REG_OE:     rd_mux = oe_q;
			board_io_pkg::REG_IN:     rd_mux = padin;
			default:                  rd_mux = '0;
		endcase
	end

	// One valid pulse per read, back to back reads allowed
	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= req.rd;
		end
	end

	always_ff @(posedge clk_bit) begin
		if (req.rd) begin
			rdata <= rd_mux;
		end
	end

	assign pad_state.padin  = padin;
	assign pad_state.padout = out_q;
	assign pad_state.padoe  = oe_q;

	// The requester must never mix a write and a read
	a_no_wr_rd: assert property (
		@(posedge clk_bit) disable iff (!rst_n_por)
		!(req.wr && req.rd)
	);

	// Two valid cycles in a row need two reads in a row
	a_valid_per_read: assert property (
		@(posedge clk_bit) disable iff (!rst_n_por)
		(rdata_valid && $past(rdata_valid)) |-> ($past(req.rd, 1) && $past(req.rd, 2))
	);

endmodule

`default_nettype wire

// ==== source/pad_input_sync.sv ====
`default_nettype none
`timescale 1ns/100ps

module pad_input_sync #(
	parameter int unsigned                         DEBOUNCE_CYCLES = 4,
	parameter logic [board_io_pkg::N_DPAD-1:0]    DPAD_INVERT     = '0
) (
	input  logic                              clk_bit,
	input  logic                              rst_n_por,
	input  logic [board_io_pkg::N_DPAD-1:0]   dpad,
	output logic [board_io_pkg::N_DPAD-1:0]   dpad_clean
);

	localparam int unsigned N_BTN = board_io_pkg::N_DPAD;
	localparam int unsigned W_CNT = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [W_CNT-1:0] CNT_LIMIT = W_CNT'(DEBOUNCE_CYCLES - 1);

	logic [N_BTN-1:0] sync_q1;
	logic [N_BTN-1:0] sync_q2;
	logic [N_BTN-1:0] level;
	logic [N_BTN-1:0] clean_q;
	logic [N_BTN-1:0] at_limit;
	logic [W_CNT-1:0] cnt_q [N_BTN];

	if (DEBOUNCE_CYCLES < 1) begin : g_bad_debounce
		$error("pad_input_sync needs DEBOUNCE_CYCLES of at least 1");
	end

	// Two flops into the bit clock domain
	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= dpad;
			sync_q2 <= sync_q1;
		end
	end

	// Board polarity applied before the compare, so accepted level is already clean
	assign level = sync_q2 ^ DPAD_INVERT;

	always_comb begin
		for (int i = 0; i < N_BTN; i++) begin
			at_limit[i] = (cnt_q[i] == CNT_LIMIT);
		end
	end

	// Each button counts its own run of differing cycles
	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			clean_q <= '0;
			for (int i = 0; i < N_BTN; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < N_BTN; i++) begin
				if (level[i] != clean_q[i]) begin
					if (at_limit[i]) begin
						clean_q[i] <= level[i];
						cnt_q[i]   <= '0;
					end else begin
						cnt_q[i] <= cnt_q[i] + 1'b1;
					end
				end else begin
					// Level went back, glitch discarded
					cnt_q[i] <= '0;
				end
			end
		end
	end

	assign dpad_clean = clean_q;

	// A clean level only moves after a full run of differing cycles
	for (genvar g = 0; g < N_BTN; g++) begin : g_chk
		a_change_at_limit: assert property (
			@(posedge clk_bit) disable iff (!rst_n_por)
			$changed(dpad_clean[g]) |-> $past(at_limit[g])
		);
	end

endmodule

`default_nettype wire

// ==== source/clock_ring_divider.sv ====
`default_nettype none
`timescale 1ns/100ps

module clock_ring_divider #(
	parameter int unsigned RATIO = 5
) (
	input  logic clk_bit,
	input  logic rst_n_por,
	output logic clk_div
);

	// Ones fill the upper half of the ring so bit 0 starts low
	localparam int unsigned N_ONES = RATIO - RATIO / 2;
	localparam logic [RATIO-1:0] RING_RESET = {RATIO{1'b1}} << (RATIO / 2);

	logic [RATIO-1:0] ring;

	if (RATIO < 2) begin : g_bad_ratio
		$error("clock_ring_divider needs RATIO of at least 2");
	end

	// Rotate right by one place each bit clock
	always_ff @(posedge clk_bit or negedge rst_n_por) begin
		if (!rst_n_por) begin
			ring <= RING_RESET;
		end else begin
			ring <= {ring[0], ring[RATIO-1:1]};
		end
	end

	// Divided clock is ring bit 0 with no compare logic
	assign clk_div = ring[0];

	// The ring never gains or loses a one
	a_ring_ones_kept: assert property (
		@(posedge clk_bit) disable iff (!rst_n_por)
		$countones(ring) == N_ONES
	);

endmodule

`default_nettype wire

// ==== source/board_io_pkg.sv ====
`default_nettype none

package board_io_pkg;

	// Pad and board counts
	localparam int unsigned N_PADS = 8;
	localparam int unsigned N_DPAD = 4;
	localparam int unsigned N_LEDS = 7;

	// Direction pad inputs occupy the low pads
	localparam int unsigned PIN_DPAD_U = 0;
	localparam int unsigned PIN_DPAD_D = 1;
	localparam int unsigned PIN_DPAD_L = 2;
	localparam int unsigned PIN_DPAD_R = 3;

	// GPIO outputs shown on the LEDs, pad 7 is a spare output
	localparam int unsigned PIN_LED0 = 4;
	localparam int unsigned PIN_LED1 = 5;
	localparam int unsigned PIN_LED2 = 6;

	// Register map of the GPIO block
	localparam int unsigned W_ADDR = 2;

	localparam logic [W_ADDR-1:0] REG_OUT    = 2'd0;
	localparam logic [W_ADDR-1:0] REG_OE     = 2'd1;
	localparam logic [W_ADDR-1:0] REG_IN     = 2'd2;
	localparam logic [W_ADDR-1:0] REG_TOGGLE = 2'd3;

	// Register port request, one access per cycle
	typedef struct packed {
		logic              wr;
		logic              rd;
		logic [W_ADDR-1:0] addr;
		logic [N_PADS-1:0] wdata;
	} gpio_req_t;

	// Pad view handed from the GPIO block to the LED driver
	typedef struct packed {
		logic [N_PADS-1:0] padin;
		logic [N_PADS-1:0] padout;
		logic [N_PADS-1:0] padoe;
	} pad_state_t;

endpackage

`default_nettype wire
